// ==== bench/blimp_clock_gen.sv ====
// Free-running 100 ns clock; rst_n low through the first four rising edges
`timescale 1ns/1ns

module blimp_clock_gen (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk   = 1'b0;
    rst_n = 1'b0;
    repeat (4) @(posedge clk);   // Four edges see reset
    rst_n <= 1'b1;               // Released on a rising edge
  end

  always #50 clk = ~clk;         // 100 ns period

endmodule

// ==== bench/blimp_golden.txt ====
// @000 record count, program length in words; @010 program, one word per pc/4
// @080 records: test, pc, waddr, wen, wdata (wdata unchecked when wen is 0)
@000
00000015 00000016
@010
00500093 00708113 002081b3 00318233 ffd00393 022202b3 00108333 02438433
022084b3 02210533 021385b3 02420633 027386b3 02408733 027107b3 02120833
021108b3 0080096f 7ff00993 00190993 00908013 00200a33
@080
00000001 00000000 00000001 00000001 00000005
00000002 00000004 00000002 00000001 0000000c
00000002 00000008 00000003 00000001 00000011
00000002 0000000c 00000004 00000001 00000022
00000003 00000010 00000007 00000001 fffffffd
00000003 00000014 00000005 00000001 00000198
00000003 00000018 00000006 00000001 0000000a
00000003 0000001c 00000008 00000001 ffffff9a
00000004 00000020 00000009 00000001 0000003c
00000004 00000024 0000000a 00000001 00000090
00000004 00000028 0000000b 00000001 fffffff1
00000004 0000002c 0000000c 00000001 00000484
00000004 00000030 0000000d 00000001 00000009
00000004 00000034 0000000e 00000001 000000aa
00000004 00000038 0000000f 00000001 ffffffdc
00000004 0000003c 00000010 00000001 000000aa
00000004 00000040 00000011 00000001 0000003c
00000005 00000044 00000012 00000001 00000048
00000005 0000004c 00000013 00000001 00000049
00000006 00000050 00000000 00000000 0000000e
00000006 00000054 00000014 00000001 0000000c

// ==== bench/blimp_props.sv ====
// Bound into writeback_commit_unit; seq width must match the ROB parameter
`timescale 1ns/1ns

module blimp_props #(
  parameter int p_seq_num_bits = 3
) (
  input logic                      clk,
  input logic                      rst_n,
  input logic                      commit_val,
  input logic [p_seq_num_bits-1:0] commit_seq,
  input logic                      alu_w_val,
  input logic [p_seq_num_bits-1:0] alu_w_seq,
  input logic                      mul_w_val,
  input logic [p_seq_num_bits-1:0] mul_w_seq
);

  int                        assert_fails = 0;  // Assertion failures so far
  logic [p_seq_num_bits-1:0] next_seq;          // Seq the next commit must carry

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)
      next_seq <= '0;                  // Head starts at zero
    else if (commit_val)
      next_seq <= next_seq + 1'b1;     // Wraps at buffer depth
  end

  // ------------------------------------------------------------
  // Commit stream properties
  // ------------------------------------------------------------

  // Sampled on the falling edge while rst_n is low
  reset_quiet: assert property (@(negedge clk) !rst_n |-> !commit_val)
    else begin
      $error("commit_val high during reset");
      assert_fails++;
    end

  commit_order: assert property (@(posedge clk) disable iff (!rst_n)
    commit_val |-> commit_seq == next_seq)
    else begin
      $error("commit seq %0d, expected %0d", commit_seq, next_seq);
      assert_fails++;
    end

  // Two writebacks in one cycle carry distinct entries
  distinct_tags: assert property (@(posedge clk) disable iff (!rst_n)
    (alu_w_val && mul_w_val) |-> alu_w_seq != mul_w_seq)
    else begin
      $error("both writeback ports carry seq %0d", alu_w_seq);
      assert_fails++;
    end

endmodule

bind writeback_commit_unit blimp_props #(
  .p_seq_num_bits (p_seq_num_bits)
) u_props (.*);

// ==== bench/blimp_tb.sv ====
// Needs bench/blimp_golden.txt from the project root; checks trace order only
`timescale 1ns/1ns

module blimp_tb;
  import blimp_pkg::*;

  localparam int    p_seq_num_bits = 3;
  localparam int    p_mul_stages   = 4;
  localparam int    prog_base      = 'h10;   // Program words in the golden image
  localparam int    rec_base       = 'h80;   // Commit records
  localparam int    rec_words      = 5;      // test, pc, waddr, wen, wdata
  localparam word_t jal_self       = 32'h0000006f;

  logic       clk, rst_n;
  word_t      inst_addr, inst_data;
  logic       trace_val, trace_wen;
  word_t      trace_pc, trace_wdata;
  logic [4:0] trace_waddr;

  word_t gold [256];
  int    rec_count, prog_len, rec_idx, cycle_cnt, limit;
  int    err_cnt, sec_err, tests_ok, tests_bad;

  blimp_clock_gen u_clock_gen (.clk(clk), .rst_n(rst_n));

  blimp_core #(
    .p_seq_num_bits (p_seq_num_bits),
    .p_mul_stages   (p_mul_stages)
  ) u_blimp_core (.*);

  // ------------------------------------------------------------
  // Instruction memory, answered in the same cycle
  // ------------------------------------------------------------

  function automatic word_t fetch_word(input word_t addr);
    if (addr[31:2] < prog_len)
      return gold[prog_base + addr[31:2]];
    return jal_self;                       // Parks the core, writes nothing
  endfunction

  always_comb inst_data = fetch_word(inst_addr);

  // ------------------------------------------------------------
  // Checks and reporting
  // ------------------------------------------------------------

  task automatic check_value(input string name, input word_t expected, input word_t actual);
    if (expected !== actual) begin
      $display("[FAIL] %s expected %08h got %08h", name, expected, actual);
      err_cnt++;
      sec_err++;
    end
  endtask

  function automatic string test_name(input word_t sec);
    case (sec)
      1:       return "reset and first commit";
      2:       return "dependent add chain";
      3:       return "mul then younger add";
      4:       return "mul run fills ROB";
      5:       return "jal link and redirect";
      6:       return "x0 writes and reads";
      default: return "unnamed";
    endcase
  endfunction

  task automatic finish_test(input word_t sec);
    if (sec_err == 0) begin
      $display("test %0d %s: ok", sec, test_name(sec));
      tests_ok++;
    end else begin
      $display("test %0d %s: %0d mismatches", sec, test_name(sec), sec_err);
      tests_bad++;
    end
    sec_err = 0;
  endtask

  // One trace_val against the next golden record
  task automatic compare_commit();
    int    base;
    word_t sec;
    base = rec_base + rec_idx * rec_words;
    sec  = gold[base];
    check_value("trace_pc", gold[base+1], trace_pc);
    check_value("trace_waddr", gold[base+2], {27'd0, trace_waddr});
    check_value("trace_wen", gold[base+3], {31'd0, trace_wen});
    if (gold[base+3][0])
      check_value("trace_wdata", gold[base+4], trace_wdata);   // Data only when written
    rec_idx++;
    if (rec_idx == rec_count || gold[base+rec_words] != sec)
      finish_test(sec);
  endtask

  initial begin
    err_cnt   = 0;
    sec_err   = 0;
    tests_ok  = 0;
    tests_bad = 0;
    rec_idx   = 0;
    cycle_cnt = 0;
    $readmemh("bench/blimp_golden.txt", gold);
    rec_count = gold[0];
    prog_len  = gold[1];
    limit     = rec_count * (p_mul_stages + 8) + 50;   // Worst case per commit
    if ($isunknown(gold[0]) || rec_count == 0) begin
      $display("Golden file bench/blimp_golden.txt missing or holds no records");
      err_cnt++;
      rec_count = 0;
    end
    while (rec_idx < rec_count && cycle_cnt < limit) begin
      @(negedge clk);                     // Trace stable mid-cycle
      if (!rst_n || cycle_cnt == 0) begin
        if (trace_val !== 1'b0) begin
          $display("trace_val was not low during or right after reset");
          err_cnt++;
        end
      end else if (trace_val) begin
        compare_commit();
      end
      if (rst_n)
        cycle_cnt++;
    end
    if (rec_idx < rec_count) begin
      $display("Timeout after %0d cycles, commits stalled at record %0d of %0d",
               cycle_cnt, rec_idx, rec_count);
      err_cnt++;
    end
    err_cnt += u_blimp_core.u_wcu.u_props.assert_fails;   // Bound assertions
    $display("Tests passed %0d, failed %0d, errors %0d", tests_ok, tests_bad, err_cnt);
    if (err_cnt == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// ==== src.f ====
verilog/blimp_pkg.sv
verilog/fetch_unit.sv
verilog/decode_issue_unit.sv
verilog/alu_unit.sv
verilog/mul_unit.sv
verilog/writeback_commit_unit.sv
verilog/blimp_core.sv
bench/blimp_clock_gen.sv
bench/blimp_props.sv
bench/blimp_tb.sv

// ==== verilog/alu_unit.sv ====
// Fixed one-cycle latency, no back-pressure; link result is pc + 4
`timescale 1ns/1ns

module alu_unit #(
  parameter int p_seq_num_bits = 3
) (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      alu_val,
  input  blimp_pkg::alu_op_e        alu_op,
  input  logic [p_seq_num_bits-1:0] x_seq,
  input  logic [4:0]                x_rd,
  input  logic                      x_wen,
  input  blimp_pkg::word_t          x_op_a,
  input  blimp_pkg::word_t          x_op_b,
  input  blimp_pkg::word_t          x_pc,
  output logic                      alu_w_val,
  output logic [p_seq_num_bits-1:0] alu_w_seq,
  output logic [4:0]                alu_w_rd,
  output logic                      alu_w_wen,
  output blimp_pkg::word_t          alu_w_data
);
  import blimp_pkg::*;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)
      alu_w_val <= 1'b0;
    else
      alu_w_val <= alu_val;
  end

  // Result and tag register
  always_ff @(posedge clk) begin
    if (alu_val) begin
      alu_w_data <= (alu_op == alu_link) ? x_pc + 32'd4 : x_op_a + x_op_b;
      alu_w_seq  <= x_seq;
      alu_w_rd   <= x_rd;
      alu_w_wen  <= x_wen;
    end
  end

endmodule

// ==== verilog/blimp_core.sv ====
// Instruction memory must answer inst_addr in the same cycle; no data memory
`timescale 1ns/1ns

module blimp_core #(
  parameter int p_seq_num_bits = 3,
  parameter int p_mul_stages   = 4
) (
  input  logic             clk,
  input  logic             rst_n,
  output blimp_pkg::word_t inst_addr,
  input  blimp_pkg::word_t inst_data,
  output logic             trace_val,
  output blimp_pkg::word_t trace_pc,
  output logic [4:0]       trace_waddr,
  output blimp_pkg::word_t trace_wdata,
  output logic             trace_wen
);
  import blimp_pkg::*;

  // ------------------------------------------------------------
  // Stage wires
  // ------------------------------------------------------------

  logic                      f_val, d_stall, redirect_val;
  word_t                     f_pc, f_inst, redirect_pc;
  logic [p_seq_num_bits-1:0] x_seq, rob_alloc_seq, commit_seq;
  logic [4:0]                x_rd, commit_rd;
  logic                      x_wen, rob_full, issue_val;
  word_t                     x_op_a, x_op_b, x_pc;
  logic                      alu_val, mul_val;
  alu_op_e                   alu_op;

  logic                      alu_w_val, alu_w_wen, mul_w_val, mul_w_wen;
  logic [p_seq_num_bits-1:0] alu_w_seq, mul_w_seq;
  logic [4:0]                alu_w_rd, mul_w_rd;
  word_t                     alu_w_data, mul_w_data;

  logic                      commit_val, commit_wen;
  word_t                     commit_data, commit_pc;

  assign issue_val = alu_val | mul_val;   // ROB allocates on either strobe

  // Trace is the commit stream
  assign trace_val   = commit_val;
  assign trace_pc    = commit_pc;
  assign trace_waddr = commit_rd;
  assign trace_wdata = commit_data;
  assign trace_wen   = commit_wen;

  // ------------------------------------------------------------
  // Units
  // ------------------------------------------------------------

  fetch_unit u_fetch (.*);

  decode_issue_unit #(
    .p_seq_num_bits (p_seq_num_bits)
  ) u_decode (.*);

  alu_unit #(
    .p_seq_num_bits (p_seq_num_bits)
  ) u_alu (.*);

  mul_unit #(
    .p_seq_num_bits (p_seq_num_bits),
    .p_mul_stages   (p_mul_stages)
  ) u_mul (.*);

  writeback_commit_unit #(
    .p_seq_num_bits (p_seq_num_bits)
  ) u_wcu (.*);

endmodule

// ==== verilog/blimp_pkg.sv ====
// TinyRV1 subset only (add, addi, mul, jal); jal immediate is not a union view
package blimp_pkg;

  // ------------------------------------------------------------
  // Opcode and function fields
  // ------------------------------------------------------------

  localparam logic [6:0] opc_add  = 7'b0110011;   // R-type arith
  localparam logic [6:0] opc_addi = 7'b0010011;   // I-type arith
  localparam logic [6:0] opc_mul  = 7'b0110011;   // Shares R-type opcode with add
  localparam logic [6:0] opc_jal  = 7'b1101111;

  localparam logic [6:0] funct7_mul = 7'b0000001; // M-extension marker

  // ALU operations
  typedef enum logic {
    alu_add  = 1'b0,   // op_a + op_b
    alu_link = 1'b1    // pc + 4
  } alu_op_e;

  typedef logic [31:0] word_t;

  // ------------------------------------------------------------
  // Instruction word, decoded as R or I format
  // ------------------------------------------------------------

  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } r;
    struct packed {
      logic [11:0] imm;     // Sign-extended at decode
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } i;
  } rv_inst_u;

endpackage

// ==== verilog/decode_issue_unit.sv ====
// No renaming or bypass: a source waits until its older write commits
`timescale 1ns/1ns

module decode_issue_unit #(
  parameter int p_seq_num_bits = 3
) (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      f_val,
  input  blimp_pkg::word_t          f_pc,
  input  blimp_pkg::word_t          f_inst,
  output logic                      d_stall,
  output logic                      redirect_val,
  output blimp_pkg::word_t          redirect_pc,
  input  logic [p_seq_num_bits-1:0] rob_alloc_seq,
  input  logic                      rob_full,
  output logic [p_seq_num_bits-1:0] x_seq,
  output logic [4:0]                x_rd,
  output logic                      x_wen,
  output blimp_pkg::word_t          x_op_a,
  output blimp_pkg::word_t          x_op_b,
  output blimp_pkg::word_t          x_pc,
  output logic                      alu_val,
  output blimp_pkg::alu_op_e        alu_op,
  output logic                      mul_val,
  input  logic                      commit_val,
  input  logic [4:0]                commit_rd,
  input  logic                      commit_wen,
  input  blimp_pkg::word_t          commit_data,
  input  logic [p_seq_num_bits-1:0] commit_seq
);
  import blimp_pkg::*;

  rv_inst_u inst;
  logic     is_add, is_addi, is_mul, is_jal;
  logic     uses_rs1, uses_rs2;
  logic     hazard, issue;
  word_t    rs1_data, rs2_data;
  word_t    imm_i, imm_j;

  word_t                     regs     [32];   // Architectural register file
  logic [31:0]               pend;            // Scoreboard, one bit per reg
  logic [p_seq_num_bits-1:0] pend_seq [32];   // Youngest writer

  assign inst = f_inst;

  // ------------------------------------------------------------
  // Decode
  // ------------------------------------------------------------

  assign is_mul  = (inst.r.opcode == opc_mul) && (inst.r.funct7 == funct7_mul);
  assign is_add  = (inst.r.opcode == opc_add) && (inst.r.funct7 != funct7_mul);
  assign is_addi = (inst.i.opcode == opc_addi);
  assign is_jal  = (inst.r.opcode == opc_jal);

  assign uses_rs1 = is_add | is_addi | is_mul;
  assign uses_rs2 = is_add | is_mul;

  assign imm_i = {{20{inst.i.imm[11]}}, inst.i.imm};
  // jal offset is scattered across the word
  assign imm_j = {{12{f_inst[31]}}, f_inst[19:12], f_inst[20], f_inst[30:21], 1'b0};

  assign rs1_data = (inst.r.rs1 == 5'd0) ? '0 : regs[inst.r.rs1];  // x0 reads zero
  assign rs2_data = (inst.r.rs2 == 5'd0) ? '0 : regs[inst.r.rs2];

  // Stall on pending source or no ROB slot
  assign hazard  = (uses_rs1 && pend[inst.r.rs1]) || (uses_rs2 && pend[inst.r.rs2]) ||
                   rob_full;
  assign d_stall = f_val && hazard;
  assign issue   = f_val && !hazard;

  // ------------------------------------------------------------
  // Issue bus
  // ------------------------------------------------------------

  assign x_seq  = rob_alloc_seq;
  assign x_rd   = inst.r.rd;
  assign x_wen  = (is_add | is_addi | is_mul | is_jal) && (inst.r.rd != 5'd0);
  assign x_op_a = rs1_data;
  assign x_op_b = is_addi ? imm_i : rs2_data;
  assign x_pc   = f_pc;

  assign alu_val = issue && !is_mul;          // Unknown opcodes go here too
  assign alu_op  = is_jal ? alu_link : alu_add;
  assign mul_val = issue && is_mul;

  // jal resolved here, same cycle as issue
  assign redirect_val = issue && is_jal;
  assign redirect_pc  = f_pc + imm_j;

  // ------------------------------------------------------------
  // Scoreboard and register file
  // ------------------------------------------------------------

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pend <= '0;
    end else begin
      // Clear only if the committer is still the youngest writer
      if (commit_val && commit_wen && pend_seq[commit_rd] == commit_seq)
        pend[commit_rd] <= 1'b0;
      if (issue && x_wen)
        pend[x_rd] <= 1'b1;                   // New writer wins
    end
  end

  always_ff @(posedge clk) begin
    if (issue && x_wen)
      pend_seq[x_rd] <= rob_alloc_seq;
    if (commit_val && commit_wen && commit_rd != 5'd0)
      regs[commit_rd] <= commit_data;         // In-order write at commit
  end

endmodule

// ==== verilog/fetch_unit.sv ====
// One word per cycle from a combinational memory; redirect wins over stall
`timescale 1ns/1ns

module fetch_unit (
  input  logic             clk,
  input  logic             rst_n,
  output blimp_pkg::word_t inst_addr,
  input  blimp_pkg::word_t inst_data,
  input  logic             d_stall,       // Level from decode
  input  logic             redirect_val,  // Pulse from decode on jal
  input  blimp_pkg::word_t redirect_pc,
  output logic             f_val,
  output blimp_pkg::word_t f_pc,
  output blimp_pkg::word_t f_inst
);
  import blimp_pkg::*;

  word_t pc;   // Address presented to memory this cycle

  assign inst_addr = pc;

  // ------------------------------------------------------------
  // PC and valid bit
  // ------------------------------------------------------------

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc    <= '0;
      f_val <= 1'b0;
    end else if (redirect_val) begin
      pc    <= redirect_pc;
      f_val <= 1'b0;          // Word behind the jal is dropped
    end else if (!d_stall) begin
      pc    <= pc + 32'd4;
      f_val <= 1'b1;
    end
    // Stall: hold everything
  end

  // Fetch register payload
  always_ff @(posedge clk) begin
    if (!redirect_val && !d_stall) begin
      f_pc   <= pc;
      f_inst <= inst_data;    // Memory answers in the same cycle
    end
  end

endmodule

// ==== verilog/mul_unit.sv ====
// Low 32 product bits only; one op per cycle, exactly p_mul_stages latency
`timescale 1ns/1ns

module mul_unit #(
  parameter int p_seq_num_bits = 3,
  parameter int p_mul_stages   = 4
) (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      mul_val,
  input  logic [p_seq_num_bits-1:0] x_seq,
  input  logic [4:0]                x_rd,
  input  logic                      x_wen,
  input  blimp_pkg::word_t          x_op_a,
  input  blimp_pkg::word_t          x_op_b,
  output logic                      mul_w_val,
  output logic [p_seq_num_bits-1:0] mul_w_seq,
  output logic [4:0]                mul_w_rd,
  output logic                      mul_w_wen,
  output blimp_pkg::word_t          mul_w_data
);
  import blimp_pkg::*;

  // ------------------------------------------------------------
  // Pipeline stages, index 0 is the first
  // ------------------------------------------------------------

  logic [p_mul_stages-1:0]   st_val;
  logic [p_seq_num_bits-1:0] st_seq  [p_mul_stages];
  logic [4:0]                st_rd   [p_mul_stages];
  logic                      st_wen  [p_mul_stages];
  word_t                     st_data [p_mul_stages];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)
      st_val <= '0;
    else
      st_val <= {st_val[p_mul_stages-2:0], mul_val};   // Shift valids
  end

  always_ff @(posedge clk) begin
    st_data[0] <= x_op_a * x_op_b;    // Truncated to 32 bits
    st_seq[0]  <= x_seq;
    st_rd[0]   <= x_rd;
    st_wen[0]  <= x_wen;
    for (int i = 1; i < p_mul_stages; i++) begin
      st_data[i] <= st_data[i-1];     // Product and tag move together
      st_seq[i]  <= st_seq[i-1];
      st_rd[i]   <= st_rd[i-1];
      st_wen[i]  <= st_wen[i-1];
    end
  end

  // Last stage is the writeback port
  assign mul_w_val  = st_val[p_mul_stages-1];
  assign mul_w_seq  = st_seq[p_mul_stages-1];
  assign mul_w_rd   = st_rd[p_mul_stages-1];
  assign mul_w_wen  = st_wen[p_mul_stages-1];
  assign mul_w_data = st_data[p_mul_stages-1];

endmodule

// ==== verilog/writeback_commit_unit.sv ====
// ROB of 2**p_seq_num_bits entries; writeback ports must carry distinct seqs
`timescale 1ns/1ns

module writeback_commit_unit #(
  parameter int p_seq_num_bits = 3
) (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      alu_w_val,
  input  logic [p_seq_num_bits-1:0] alu_w_seq,
  input  logic [4:0]                alu_w_rd,
  input  logic                      alu_w_wen,
  input  blimp_pkg::word_t          alu_w_data,
  input  logic                      mul_w_val,
  input  logic [p_seq_num_bits-1:0] mul_w_seq,
  input  logic [4:0]                mul_w_rd,
  input  logic                      mul_w_wen,
  input  blimp_pkg::word_t          mul_w_data,
  input  blimp_pkg::word_t          x_pc,
  input  logic                      issue_val,
  output logic [p_seq_num_bits-1:0] rob_alloc_seq,
  output logic                      rob_full,
  output logic                      commit_val,
  output logic [p_seq_num_bits-1:0] commit_seq,
  output logic [4:0]                commit_rd,
  output logic                      commit_wen,
  output blimp_pkg::word_t          commit_data,
  output blimp_pkg::word_t          commit_pc
);
  import blimp_pkg::*;

  localparam int p_depth = 2 ** p_seq_num_bits;

  logic [p_seq_num_bits-1:0] head;        // Oldest in flight
  logic [p_seq_num_bits-1:0] tail;        // Next to allocate
  logic [p_seq_num_bits:0]   count;       // One extra bit for full
  logic [p_depth-1:0]        rob_done;

  word_t      rob_pc   [p_depth];
  logic [4:0] rob_rd   [p_depth];
  logic       rob_wen  [p_depth];
  word_t      rob_data [p_depth];

  assign rob_alloc_seq = tail;
  assign rob_full      = (count == (p_seq_num_bits+1)'(p_depth));

  // ------------------------------------------------------------
  // Commit from head, one per cycle
  // ------------------------------------------------------------

  assign commit_val  = rob_done[head];    // Done bit set at least a cycle ago
  assign commit_seq  = head;
  assign commit_rd   = rob_rd[head];
  assign commit_wen  = rob_wen[head];
  assign commit_data = rob_data[head];
  assign commit_pc   = rob_pc[head];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      head     <= '0;
      tail     <= '0;
      count    <= '0;
      rob_done <= '0;
    end else begin
      if (issue_val) begin
        rob_done[tail] <= 1'b0;           // Fresh entry
        tail           <= tail + 1'b1;
      end
      if (alu_w_val) rob_done[alu_w_seq] <= 1'b1;
      if (mul_w_val) rob_done[mul_w_seq] <= 1'b1;
      if (commit_val) begin
        rob_done[head] <= 1'b0;
        head           <= head + 1'b1;    // Wraps with the buffer
      end
      case ({issue_val, commit_val})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;          // Both or neither
      endcase
    end
  end

  // Entry payload
  always_ff @(posedge clk) begin
    if (issue_val)
      rob_pc[tail] <= x_pc;
    if (alu_w_val) begin
      rob_rd[alu_w_seq]   <= alu_w_rd;
      rob_wen[alu_w_seq]  <= alu_w_wen;
      rob_data[alu_w_seq] <= alu_w_data;
    end
    if (mul_w_val) begin
      rob_rd[mul_w_seq]   <= mul_w_rd;
      rob_wen[mul_w_seq]  <= mul_w_wen;
      rob_data[mul_w_seq] <= mul_w_data;
    end
  end

endmodule
